/* common/fetch_pkg.sv */
////////////////////
// Fetch front end shared definitions
// Cache bus commands and responses, decode and debug commands,
// fetch item kinds and instruction cache geometry
////////////////////
package fetch_pkg;

    // Command presented by fetch on the cache bus
    typedef enum logic [1:0] {
        CACHE_CMD_NONE,
        CACHE_CMD_EXECUTE,
        CACHE_CMD_FLUSH_ALL
    } cache_cmd_e;

    // Cache answer, valid in the done cycle
    typedef enum logic [1:0] {
        CACHE_RESP_OK,
        CACHE_RESP_ACCESS_FAULT
    } cache_resp_e;

    // Decode to fetch commands
    typedef enum logic [1:0] {
        D2F_CMD_NONE,
        D2F_CMD_FLUSH,
        D2F_CMD_BRANCH
    } d2f_cmd_e;

    // Kind of item handed to decode
    typedef enum logic {
        F2D_TYPE_INSTR,
        F2D_TYPE_INTERRUPT_PENDING
    } f2d_type_e;

    typedef enum logic [1:0] {
        DBG_CMD_NOP,
        DBG_CMD_JUMP
    } dbg_cmd_e;

    ////////////////////
    // Memory and cache geometry
    ////////////////////
    localparam int ROM_WORDS      = 32;
    localparam int ROM_ADDR_W     = $clog2(ROM_WORDS);
    localparam logic [31:0] ROM_BYTES = 32'(ROM_WORDS * 4);
    localparam int ICACHE_LINES   = 8;
    localparam int ICACHE_INDEX_W = $clog2(ICACHE_LINES);
    // Word address bits above the line index
    localparam int ICACHE_TAG_W   = 30 - ICACHE_INDEX_W;
    localparam int MISS_LATENCY   = 3;
    localparam int MISS_CNT_W     = $clog2(MISS_LATENCY + 1);
    localparam string ROM_FILE    = "program.hex";

endpackage

/* common/cache_bus_if.sv */
////////////////////
// Fetch to instruction cache command bus
// Command and address stay put until done
////////////////////
`timescale 1ns/1ns

interface cache_bus_if import fetch_pkg::*; ();

    // Driven by fetch
    cache_cmd_e  cmd;
    logic [31:0] address;

    // Driven by the cache
    logic        done;
    cache_resp_e resp;
    logic [31:0] load_data;

    modport fetch (
        output cmd, address,
        input  done, resp, load_data
    );

    modport cache (
        input  cmd, address,
        output done, resp, load_data
    );

endinterface

/* fetch/fetch_unit.sv */
////////////////////
// Fetch unit
// Issues one cache command at a time, follows pc+4 or a redirect,
// hands instructions to decode over valid/ready and parks under debug
////////////////////
`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] reset_vector,

    cache_bus_if.fetch  cache,

    input  logic        interrupt_pending,

    // Debug port
    input  logic        dbg_mode,
    input  logic        dbg_cmd_valid,
    input  dbg_cmd_e    dbg_cmd,
    input  logic [31:0] dbg_arg0,
    output logic        dbg_cmd_ready,
    output logic        dbg_pipeline_busy,

    // Towards decode
    output logic        f2d_valid,
    output f2d_type_e   f2d_type,
    output logic [31:0] f2d_instr,
    output logic [31:0] f2d_pc,
    output cache_resp_e f2d_resp,

    // From decode
    input  logic        d2f_ready,
    input  d2f_cmd_e    d2f_cmd,
    input  logic [31:0] d2f_branch_target
);

    ////////////////////
    // State
    ////////////////////
    // Command and address that were on the bus last cycle
    cache_cmd_e  active_cmd;
    logic [31:0] pc;

    // Response kept for decode while it stalls
    logic        saved_valid;
    logic        saved_valid_nxt;
    logic [31:0] saved_instr;
    cache_resp_e saved_resp;

    // Redirects that wait for the unit to become free
    logic        branched;
    logic        branched_nxt;
    logic [31:0] branch_target;
    logic [31:0] branch_target_nxt;
    logic        flushed;
    logic        flushed_nxt;

    logic        active;
    logic        resp_present;
    logic        free;

    assign active = (active_cmd != CACHE_CMD_NONE);

    // Fetch result goes to decode unless a redirect made it stale
    assign resp_present = active && cache.done &&
                          (active_cmd == CACHE_CMD_EXECUTE) && !branched;

    // Free to put a new command on the bus this cycle
    assign free = saved_valid ? d2f_ready
                              : (!active || (cache.done && (d2f_ready || !resp_present)));

    always_comb begin
        cache.cmd         = active_cmd;
        cache.address     = pc;
        f2d_valid         = 1'b0;
        f2d_type          = F2D_TYPE_INSTR;
        f2d_instr         = cache.load_data;
        f2d_pc            = pc;
        f2d_resp          = cache.resp;
        dbg_cmd_ready     = 1'b0;
        dbg_pipeline_busy = 1'b1;
        saved_valid_nxt   = saved_valid;
        branched_nxt      = branched;
        branch_target_nxt = branch_target;
        flushed_nxt       = flushed;

        // Decode commands count only with ready, remember them at once
        if (d2f_ready && (d2f_cmd == D2F_CMD_FLUSH)) begin
            flushed_nxt = 1'b1;
        end
        if (d2f_ready && (d2f_cmd == D2F_CMD_BRANCH)) begin
            branched_nxt      = 1'b1;
            branch_target_nxt = d2f_branch_target;
        end

        ////////////////////
        // Item offered to decode
        ////////////////////
        if (saved_valid) begin
            f2d_valid = 1'b1;
            f2d_instr = saved_instr;
            f2d_resp  = saved_resp;
        end else if (resp_present) begin
            // Straight from the cache in the done cycle
            f2d_valid = 1'b1;
        end else if (!active && interrupt_pending) begin
            f2d_valid = 1'b1;
            f2d_type  = F2D_TYPE_INTERRUPT_PENDING;
        end

        ////////////////////
        // Next command
        ////////////////////
        if (free) begin
            saved_valid_nxt = 1'b0;
            if (dbg_mode) begin
                // Parked, debug may only act once nothing is in flight
                cache.cmd         = CACHE_CMD_NONE;
                dbg_pipeline_busy = active || saved_valid;
                if (!active && !saved_valid && dbg_cmd_valid) begin
                    dbg_cmd_ready = 1'b1;
                    if (dbg_cmd == DBG_CMD_JUMP) begin
                        branched_nxt      = 1'b1;
                        branch_target_nxt = dbg_arg0;
                    end
                end
            end else if (interrupt_pending) begin
                // Hold until the interrupt is taken
                cache.cmd = CACHE_CMD_NONE;
            end else if (flushed_nxt) begin
                cache.cmd   = CACHE_CMD_FLUSH_ALL;
                flushed_nxt = 1'b0;
            end else if (branched_nxt) begin
                cache.cmd     = CACHE_CMD_EXECUTE;
                cache.address = branch_target_nxt;
                branched_nxt  = 1'b0;
            end else begin
                cache.cmd     = CACHE_CMD_EXECUTE;
                cache.address = pc + 32'd4;
            end
        end else if (cache.done) begin
            // Decode stalls on a fresh response, keep it and go quiet
            cache.cmd       = CACHE_CMD_NONE;
            saved_valid_nxt = 1'b1;
        end

        // Nothing leaves the unit during reset
        if (!rst_n) begin
            cache.cmd     = CACHE_CMD_NONE;
            cache.address = reset_vector;
            f2d_valid     = 1'b0;
            dbg_cmd_ready = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_cmd    <= CACHE_CMD_NONE;
            saved_valid   <= 1'b0;
            flushed       <= 1'b0;
            // Start as if a branch to the reset vector was taken
            branched      <= 1'b1;
            branch_target <= reset_vector;
        end else begin
            active_cmd    <= cache.cmd;
            saved_valid   <= saved_valid_nxt;
            flushed       <= flushed_nxt;
            branched      <= branched_nxt;
            branch_target <= branch_target_nxt;
        end
    end

    always_ff @(posedge clk) begin
        pc <= cache.address;
        // Track the bus until a stall freezes the copy
        if (!saved_valid) begin
            saved_instr <= cache.load_data;
            saved_resp  <= cache.resp;
        end
    end

endmodule

/* icache/icache.sv */
////////////////////
// Direct-mapped instruction cache
// One word per line, refilled from a word ROM after a fixed delay,
// flush-all and access faults past the end of the ROM
////////////////////
`timescale 1ns/1ns

module icache import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    cache_bus_if.cache cache
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_RESPOND
    } state_e;

    state_e state;

    // Line storage
    logic [ICACHE_LINES-1:0] line_valid;
    logic [ICACHE_TAG_W-1:0] tags [ICACHE_LINES];
    logic [31:0]             data [ICACHE_LINES];

    // Backing ROM
    logic [31:0] rom [ROM_WORDS];

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    // Request being refilled
    logic [31:0]           fill_addr;
    logic [MISS_CNT_W-1:0] miss_cnt;
    logic [31:0]           load_data;
    cache_resp_e           resp;

    logic [ICACHE_INDEX_W-1:0] req_index;
    logic [ICACHE_TAG_W-1:0]   req_tag;
    logic                      hit;
    logic                      fault;
    logic [ICACHE_INDEX_W-1:0] fill_index;

    // Lookup on the address presented this cycle
    assign req_index  = cache.address[2 +: ICACHE_INDEX_W];
    assign req_tag    = cache.address[31 -: ICACHE_TAG_W];
    assign hit        = line_valid[req_index] && (tags[req_index] == req_tag);
    assign fault      = (cache.address >= ROM_BYTES);
    assign fill_index = fill_addr[2 +: ICACHE_INDEX_W];

    assign cache.done      = (state == ST_RESPOND);
    assign cache.resp      = resp;
    assign cache.load_data = load_data;

    ////////////////////
    // Control
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            line_valid <= '0;
        end else if (state == ST_REFILL) begin
            if (miss_cnt == '0) begin
                state                  <= ST_RESPOND;
                line_valid[fill_index] <= 1'b1;
            end
        end else if (cache.cmd == CACHE_CMD_FLUSH_ALL) begin
            // Idle or done cycle, a new command is taken here
            line_valid <= '0;
            state      <= ST_RESPOND;
        end else if (cache.cmd == CACHE_CMD_EXECUTE) begin
            // Faults bypass the lines
            state <= (hit || fault) ? ST_RESPOND : ST_REFILL;
        end else begin
            state <= ST_IDLE;
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (state == ST_REFILL) begin
            miss_cnt <= miss_cnt - 1'b1;
            if (miss_cnt == '0) begin
                tags[fill_index] <= fill_addr[31 -: ICACHE_TAG_W];
                data[fill_index] <= rom[fill_addr[2 +: ROM_ADDR_W]];
                load_data        <= rom[fill_addr[2 +: ROM_ADDR_W]];
                resp             <= CACHE_RESP_OK;
            end
        end else if (cache.cmd != CACHE_CMD_NONE) begin
            fill_addr <= cache.address;
            miss_cnt  <= MISS_CNT_W'(MISS_LATENCY - 1);
            if ((cache.cmd == CACHE_CMD_EXECUTE) && fault) begin
                resp      <= CACHE_RESP_ACCESS_FAULT;
                load_data <= '0;
            end else begin
                resp      <= CACHE_RESP_OK;
                load_data <= hit ? data[req_index] : '0;
            end
        end
    end

endmodule

/* design/fetch_top.sv */
////////////////////
// Fetch front end top
// Fetch unit and instruction cache joined by the cache bus
////////////////////
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] reset_vector,
    input  logic        interrupt_pending,

    // Debug port
    input  logic        dbg_mode,
    input  logic        dbg_cmd_valid,
    input  dbg_cmd_e    dbg_cmd,
    input  logic [31:0] dbg_arg0,
    output logic        dbg_cmd_ready,
    output logic        dbg_pipeline_busy,

    // Decode port
    output logic        f2d_valid,
    output f2d_type_e   f2d_type,
    output logic [31:0] f2d_instr,
    output logic [31:0] f2d_pc,
    output cache_resp_e f2d_resp,
    input  logic        d2f_ready,
    input  d2f_cmd_e    d2f_cmd,
    input  logic [31:0] d2f_branch_target
);

    cache_bus_if i_cache_bus ();

    fetch_unit i_fetch_unit (
        .clk               (clk),
        .rst_n             (rst_n),
        .reset_vector      (reset_vector),
        .cache             (i_cache_bus.fetch),
        .interrupt_pending (interrupt_pending),
        .dbg_mode          (dbg_mode),
        .dbg_cmd_valid     (dbg_cmd_valid),
        .dbg_cmd           (dbg_cmd),
        .dbg_arg0          (dbg_arg0),
        .dbg_cmd_ready     (dbg_cmd_ready),
        .dbg_pipeline_busy (dbg_pipeline_busy),
        .f2d_valid         (f2d_valid),
        .f2d_type          (f2d_type),
        .f2d_instr         (f2d_instr),
        .f2d_pc            (f2d_pc),
        .f2d_resp          (f2d_resp),
        .d2f_ready         (d2f_ready),
        .d2f_cmd           (d2f_cmd),
        .d2f_branch_target (d2f_branch_target)
    );

    icache i_icache (
        .clk   (clk),
        .rst_n (rst_n),
        .cache (i_cache_bus.cache)
    );

endmodule

/* tb/fetch_tb.sv */
////////////////////
// Fetch front end testbench
// Random decode stalls, branches, flush, faults, interrupt and a
// debug jump, checked by assertions against a ROM reference model
////////////////////
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] RESET_PC = 32'h0000_0010;
    // Decode stalls roughly one cycle in four
    localparam int STALL_ONE_IN = 4;
    // Transfers the sequence below asks for, rounded up
    localparam int PLANNED      = 60;
    localparam int WATCHDOG_NS  = (PLANNED * 40 + 200) * CLK_PERIOD;
    localparam int WAIT_LIMIT   = 64;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] reset_vector;
    logic        interrupt_pending;
    logic        dbg_mode;
    logic        dbg_cmd_valid;
    dbg_cmd_e    dbg_cmd;
    logic [31:0] dbg_arg0;
    logic        dbg_cmd_ready;
    logic        dbg_pipeline_busy;
    logic        f2d_valid;
    f2d_type_e   f2d_type;
    logic [31:0] f2d_instr;
    logic [31:0] f2d_pc;
    cache_resp_e f2d_resp;
    logic        d2f_ready;
    d2f_cmd_e    d2f_cmd;
    logic [31:0] d2f_branch_target;

    int seed;
    int errors    = 0;
    int transfers = 0;
    int faults    = 0;
    int irqs      = 0;
    int dbg_jumps = 0;

    // Reference model state
    logic [31:0] ref_rom [ROM_WORDS];
    logic [31:0] exp_pc;
    logic        exp_in_rom;
    logic [31:0] exp_instr;
    cache_resp_e exp_resp;
    logic        irq_taken;
    logic        idle_seen;
    logic        instr_accept;

    // Copy of the item offered during a stall
    logic        prev_hold;
    f2d_type_e   prev_type;
    logic [31:0] prev_instr;
    logic [31:0] prev_pc;
    cache_resp_e prev_resp;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fetch_top i_fetch_top (.*);

    initial begin
        $readmemh(ROM_FILE, ref_rom);
    end

    // Outside the ROM the answer is a fault with zero data
    assign exp_in_rom   = (exp_pc < ROM_BYTES);
    assign exp_instr    = exp_in_rom ? ref_rom[exp_pc[2 +: ROM_ADDR_W]] : 32'h0;
    assign exp_resp     = exp_in_rom ? CACHE_RESP_OK : CACHE_RESP_ACCESS_FAULT;
    assign instr_accept = f2d_valid && d2f_ready && (f2d_type == F2D_TYPE_INSTR);

    ////////////////////
    // Reference model
    ////////////////////
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc    <= reset_vector;
            irq_taken <= 1'b0;
            prev_hold <= 1'b0;
            idle_seen <= 1'b0;
        end else begin
            // Interrupt items are a level, only instr items must hold
            prev_hold  <= f2d_valid && !d2f_ready && (f2d_type == F2D_TYPE_INSTR);
            prev_type  <= f2d_type;
            prev_instr <= f2d_instr;
            prev_pc    <= f2d_pc;
            prev_resp  <= f2d_resp;
            idle_seen  <= dbg_mode && !dbg_pipeline_busy;
            if (f2d_valid && d2f_ready) begin
                if (f2d_type == F2D_TYPE_INSTR) begin
                    transfers <= transfers + 1;
                    exp_pc    <= exp_pc + 32'd4;
                    if (f2d_resp == CACHE_RESP_ACCESS_FAULT) begin
                        faults <= faults + 1;
                    end
                end else begin
                    irqs      <= irqs + 1;
                    irq_taken <= 1'b1;
                end
            end
            // Redirects win over the pc+4 step in the same cycle
            if (d2f_ready && (d2f_cmd == D2F_CMD_BRANCH)) begin
                exp_pc    <= d2f_branch_target;
                irq_taken <= 1'b0;
            end
            if (dbg_cmd_ready && (dbg_cmd == DBG_CMD_JUMP)) begin
                exp_pc    <= dbg_arg0;
                dbg_jumps <= dbg_jumps + 1;
            end
        end
    end

    ////////////////////
    // Assertions
    ////////////////////
    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
            instr_accept |-> (f2d_pc == exp_pc))
        else begin
            errors++;
            $display("Error: f2d_pc %h expected %h", $sampled(f2d_pc), $sampled(exp_pc));
        end

    a_instr: assert property (@(posedge clk) disable iff (!rst_n)
            instr_accept |-> (f2d_instr == exp_instr))
        else begin
            errors++;
            $display("Error: f2d_instr %h expected %h at pc %h",
                     $sampled(f2d_instr), $sampled(exp_instr), $sampled(f2d_pc));
        end

    a_resp: assert property (@(posedge clk) disable iff (!rst_n)
            instr_accept |-> (f2d_resp == exp_resp))
        else begin
            errors++;
            $display("Error: f2d_resp %h expected %h at pc %h",
                     $sampled(f2d_resp), $sampled(exp_resp), $sampled(f2d_pc));
        end

    // Stalled item must not move
    a_hold_type: assert property (@(posedge clk) disable iff (!rst_n)
            prev_hold |-> (f2d_type == prev_type))
        else begin
            errors++;
            $display("Error: f2d_type %h changed from %h", $sampled(f2d_type), $sampled(prev_type));
        end

    a_hold_instr: assert property (@(posedge clk) disable iff (!rst_n)
            prev_hold |-> (f2d_instr == prev_instr))
        else begin
            errors++;
            $display("Error: f2d_instr %h changed from %h",
                     $sampled(f2d_instr), $sampled(prev_instr));
        end

    a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n)
            prev_hold |-> (f2d_pc == prev_pc))
        else begin
            errors++;
            $display("Error: f2d_pc %h changed from %h", $sampled(f2d_pc), $sampled(prev_pc));
        end

    a_hold_resp: assert property (@(posedge clk) disable iff (!rst_n)
            prev_hold |-> (f2d_resp == prev_resp))
        else begin
            errors++;
            $display("Error: f2d_resp %h changed from %h", $sampled(f2d_resp), $sampled(prev_resp));
        end

    // Fetch stays parked after the interrupt item until a branch
    a_irq_hold: assert property (@(posedge clk) disable iff (!rst_n)
            instr_accept |-> !irq_taken)
        else begin
            errors++;
            $display("Instruction at pc %h accepted after the interrupt item", $sampled(f2d_pc));
        end

    a_dbg_ready: assert property (@(posedge clk) disable iff (!rst_n)
            dbg_cmd_ready |-> (dbg_mode && dbg_cmd_valid))
        else begin
            errors++;
            $display("Error: dbg_cmd_ready %h without a debug command", $sampled(dbg_cmd_ready));
        end

    ////////////////////
    // Decode and debug drivers
    ////////////////////
    task automatic next_cycle();
        @(negedge clk);
        d2f_ready = ($random(seed) % STALL_ONE_IN) != 0;
        d2f_cmd   = D2F_CMD_NONE;
    endtask

    task automatic give_cmd(input d2f_cmd_e cmd, input logic [31:0] target);
        @(negedge clk);
        d2f_ready         = 1'b1;
        d2f_cmd           = cmd;
        d2f_branch_target = target;
    endtask

    // Run until n more instr items went to decode
    task automatic stream(input int n);
        int goal;
        goal = transfers + n;
        while (transfers < goal) begin
            next_cycle();
        end
    endtask

    task automatic take_interrupt(input logic [31:0] target);
        int goal;
        int n;
        goal = irqs + 1;
        n    = 0;
        next_cycle();
        interrupt_pending = 1'b1;
        while ((irqs < goal) && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (irqs < goal) begin
            errors++;
            $display("No interrupt item accepted within %0d cycles", WAIT_LIMIT);
        end
        repeat (3) next_cycle();
        // Handler entry: interrupt drops as decode branches
        @(negedge clk);
        interrupt_pending = 1'b0;
        d2f_ready         = 1'b1;
        d2f_cmd           = D2F_CMD_BRANCH;
        d2f_branch_target = target;
    endtask

    task automatic debug_jump(input logic [31:0] target);
        int goal;
        int n;
        goal = dbg_jumps + 1;
        n    = 0;
        next_cycle();
        dbg_mode = 1'b1;
        while (!idle_seen && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (!idle_seen) begin
            errors++;
            $display("Debug pipeline still busy after %0d cycles", WAIT_LIMIT);
        end
        dbg_cmd_valid = 1'b1;
        dbg_cmd       = DBG_CMD_JUMP;
        dbg_arg0      = target;
        n             = 0;
        while ((dbg_jumps < goal) && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        dbg_cmd_valid = 1'b0;
        dbg_cmd       = DBG_CMD_NOP;
        if (dbg_jumps < goal) begin
            errors++;
            $display("Debug jump was not accepted within %0d cycles", WAIT_LIMIT);
        end
        repeat (2) next_cycle();
        dbg_mode = 1'b0;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        seed              = 32'h99d3_a2ff;
        rst_n             = 1'b0;
        reset_vector      = RESET_PC;
        interrupt_pending = 1'b0;
        dbg_mode          = 1'b0;
        dbg_cmd_valid     = 1'b0;
        dbg_cmd           = DBG_CMD_NOP;
        dbg_arg0          = 32'h0;
        d2f_ready         = 1'b0;
        d2f_cmd           = D2F_CMD_NONE;
        d2f_branch_target = 32'h0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Cold misses from the reset vector
        stream(12);
        // Back into lines that are still cached
        give_cmd(D2F_CMD_BRANCH, 32'h0000_0020);
        stream(10);
        give_cmd(D2F_CMD_FLUSH, 32'h0);
        stream(6);
        // Past the end of the ROM
        give_cmd(D2F_CMD_BRANCH, 32'h0000_0200);
        stream(2);
        // Last ROM words, then over the edge
        give_cmd(D2F_CMD_BRANCH, 32'h0000_0070);
        stream(6);
        take_interrupt(32'h0000_0040);
        stream(4);
        debug_jump(32'h0000_0014);
        stream(4);

        if ((faults == 0) || (irqs == 0) || (dbg_jumps == 0)) begin
            errors++;
            $display("Fault, interrupt or debug jump never happened");
        end
        $display("Transfers %0d, faults %0d, interrupts %0d, debug jumps %0d, errors %0d",
                 transfers, faults, irqs, dbg_jumps, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Run did not finish within %0d ns, transfers %0d, errors %0d",
                 WATCHDOG_NS, transfers, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* program.hex */
// One 32-bit instruction word per line in hex
// First line is word address 0, 32 words in total
00100093
00200113
00308193
00410213
00518293
00620313
00728393
00830413
00938493
00a40513
00b48593
00c50613
00d58693
00e60713
00f68793
01070813
002081b3
40110233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
00112023
00012503
fe209ee3
00408093
00c000ef
000080e7
12345537
00001597
00100073

/* verilog.f */
common/fetch_pkg.sv
common/cache_bus_if.sv
fetch/fetch_unit.sv
icache/icache.sv
design/fetch_top.sv
tb/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module fetch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vfetch_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^PASS: all tests$"; then
    exit 0
fi
exit 1
